// ==== sources.f ====
game_pkg.sv
video_pkg.sv
game_sequencer.sv
level_loader.sv
grid_memory.sv
draw_grid.sv
player_updater.sv
hex_digit.sv
maze_top.sv
tb_clock.sv
tb_maze.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the maze testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
    --top-module tb_maze -Mdir obj_dir -o tb_maze_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_maze_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== tb_maze.sv ====
`timescale 1ns/1ps

module tb_maze;

    localparam game_pkg::pos_x_t START_X   = 384;
    localparam game_pkg::pos_y_t START_Y   = 384;
    localparam int               MOVE_STEP = 16;
    localparam game_pkg::angle_t TURN_STEP = 64;

    localparam int FRAMES          = 150;
    localparam int PIXELS          = 8192;
    localparam int LINE_PIXELS     = 128;
    localparam int MIN_LOAD_CYCLES = 2053;
    localparam int STEER_FRAME     = 60;

    // Lit segments gfedcba in active-high form
    localparam logic [6:0] LIT [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    logic                 clock;
    logic                 reset;
    logic                 turn_right;
    logic                 turn_left;
    logic                 move_forward;
    logic                 move_backward;
    video_pkg::segments_t hex7;
    video_pkg::segments_t hex6;
    video_pkg::segments_t hex5;
    video_pkg::segments_t hex4;
    video_pkg::vga_x_t    vga_x;
    video_pkg::vga_y_t    vga_y;
    video_pkg::colour_t   vga_colour;
    logic                 vga_write;

    integer seed = 32'h9ca5_68f9;

    int pixel_errors   = 0;
    int segment_errors = 0;
    int count_errors   = 0;
    int other_errors   = 0;
    int blocked_moves  = 0;

    // Reference player state
    game_pkg::pos_x_t model_x     = START_X;
    game_pkg::pos_y_t model_y     = START_Y;
    game_pkg::angle_t model_angle = '0;

    tb_clock #(.PERIOD(100)) i_tb_clock (.clock(clock));

    maze_top #(
        .START_X(START_X), .START_Y(START_Y),
        .MOVE_STEP(MOVE_STEP), .TURN_STEP(TURN_STEP)
    ) i_maze_top (
        .clock(clock), .reset(reset),
        .turn_right(turn_right), .turn_left(turn_left),
        .move_forward(move_forward), .move_backward(move_backward),
        .hex7(hex7), .hex6(hex6), .hex5(hex5), .hex4(hex4),
        .vga_x(vga_x), .vga_y(vga_y), .vga_colour(vga_colour), .vga_write(vga_write)
    );

    // Border ring plus a pillar where both indices are 4 mod 8
    function automatic bit is_wall(input int cx, input int cy);
        return cx == 0 || cx == 63 || cy == 0 || cy == 31 || (cx % 8 == 4 && cy % 8 == 4);
    endfunction

    function automatic video_pkg::segments_t segments_for(input logic [3:0] digit);
        return video_pkg::segments_t'(~LIT[digit]);
    endfunction

    task automatic next_cycle;
        @(posedge clock);
        #1;
    endtask

    task automatic check_pixel(input video_pkg::vga_x_t x, input video_pkg::vga_y_t y,
                               input video_pkg::colour_t colour,
                               input video_pkg::vga_x_t exp_x, input video_pkg::vga_y_t exp_y,
                               input video_pkg::colour_t exp_colour);
        if (x !== exp_x || y !== exp_y || colour !== exp_colour) begin
            pixel_errors++;
            $display("Mismatch vga_x/vga_y/vga_colour: got %h/%h/%h expected %h/%h/%h",
                     x, y, colour, exp_x, exp_y, exp_colour);
        end
    endtask

    task automatic check_segments(input string name, input video_pkg::segments_t actual,
                                  input video_pkg::segments_t expected);
        if (actual !== expected) begin
            segment_errors++;
            $display("Mismatch %s: got %h expected %h", name, actual, expected);
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            count_errors++;
            $display("Mismatch %s: got %h expected %h", name, actual, expected);
        end
    endtask

    // X low byte on hex7/hex6 and Y low byte on hex5/hex4
    task automatic check_position;
        check_segments("hex7", hex7, segments_for(model_x[7:4]));
        check_segments("hex6", hex6, segments_for(model_x[3:0]));
        check_segments("hex5", hex5, segments_for(model_y[7:4]));
        check_segments("hex4", hex4, segments_for(model_y[3:0]));
    endtask

    task automatic wait_for_write(input int limit, output int cycles);
        cycles = 0;
        while (vga_write !== 1'b1 && cycles < limit) begin
            next_cycle();
            cycles++;
        end
    endtask

    task automatic scan_frame(output int writes);
        int col;
        int row;
        video_pkg::colour_t colour;
        writes = 0;
        while (vga_write === 1'b1 && writes <= PIXELS) begin
            col = writes % LINE_PIXELS;
            row = writes / LINE_PIXELS;
            colour = is_wall(col / 2, row / 2) ? video_pkg::COLOUR_WALL : video_pkg::COLOUR_EMPTY;
            check_pixel(vga_x, vga_y, vga_colour,
                        video_pkg::vga_x_t'(col), video_pkg::vga_y_t'(row), colour);
            writes++;
            next_cycle();
        end
    endtask

    task automatic choose_buttons(input int frame);
        logic [31:0] r;
        r = $random(seed);
        // Without a wall hit yet the player heads for the left border and pushes into it
        if (frame >= STEER_FRAME && blocked_moves == 0) begin
            case (model_angle[7:6])
                2'd0:    r[3:0] = 4'b0001;
                2'd1:    r[3:0] = 4'b1000;
                2'd2:    r[3:0] = 4'b0010;
                default: r[3:0] = 4'b0100;
            endcase
        end
        {turn_right, turn_left, move_forward, move_backward} = r[3:0];
    endtask

    task automatic update_model;
        int quadrant;
        int dx;
        int dy;
        game_pkg::pos_x_t cand_x;
        game_pkg::pos_y_t cand_y;
        quadrant = int'(model_angle[7:6]);
        if (move_backward && !move_forward) begin
            quadrant = (quadrant + 2) % 4;
        end
        dx = 0;
        dy = 0;
        if (move_forward || move_backward) begin
            case (quadrant)
                0:       dx = MOVE_STEP;
                1:       dy = MOVE_STEP;
                2:       dx = -MOVE_STEP;
                default: dy = -MOVE_STEP;
            endcase
        end
        cand_x = game_pkg::pos_x_t'(int'(model_x) + dx);
        cand_y = game_pkg::pos_y_t'(int'(model_y) + dy);
        if (is_wall((int'(cand_x) >> game_pkg::CELL_SHIFT) % 64,
                    (int'(cand_y) >> game_pkg::CELL_SHIFT) % 32)) begin
            blocked_moves++;
        end else begin
            model_x = cand_x;
            model_y = cand_y;
        end
        if (turn_right) begin
            model_angle = model_angle + TURN_STEP;
        end else if (turn_left) begin
            model_angle = model_angle - TURN_STEP;
        end
    endtask

    initial begin
        int cycles;
        int writes;
        bit timed_out;
        reset         = 1'b1;
        turn_right    = 1'b0;
        turn_left     = 1'b0;
        move_forward  = 1'b0;
        move_backward = 1'b0;
        timed_out     = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        if (vga_write !== 1'b0) begin
            other_errors++;
            $display("vga_write is high while reset is asserted");
        end
        check_position();
        reset = 1'b0;
        for (int frame = 0; frame < FRAMES && !timed_out; frame++) begin
            wait_for_write(frame == 0 ? 5000 : 100, cycles);
            if (vga_write !== 1'b1) begin
                other_errors++;
                timed_out = 1'b1;
                $display("Timeout: frame %0d never started writing pixels", frame);
            end else begin
                if (frame == 0 && cycles < MIN_LOAD_CYCLES) begin
                    other_errors++;
                    $display("vga_write rose after %0d cycles, before the maze was loaded",
                             cycles);
                end
                check_position();
                // The last frame has no following frame to show its update
                if (frame < FRAMES - 1) begin
                    choose_buttons(frame);
                    update_model();
                end
                scan_frame(writes);
                check_count("frame writes", writes, PIXELS);
            end
        end
        if (!timed_out && blocked_moves == 0) begin
            other_errors++;
            $display("No move was ever blocked by a wall");
        end
        $display("Errors: pixel %0d, segments %0d, count %0d, other %0d (blocked moves %0d)",
                 pixel_errors, segment_errors, count_errors, other_errors, blocked_moves);
        if (pixel_errors + segment_errors + count_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

endmodule

// ==== maze_top.sv ====
`timescale 1ns/1ps

module maze_top #(
    parameter game_pkg::pos_x_t START_X   = 384,
    parameter game_pkg::pos_y_t START_Y   = 384,
    parameter int               MOVE_STEP = 16,
    parameter game_pkg::angle_t TURN_STEP = 64
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 turn_right,
    input  logic                 turn_left,
    input  logic                 move_forward,
    input  logic                 move_backward,
    output video_pkg::segments_t hex7,
    output video_pkg::segments_t hex6,
    output video_pkg::segments_t hex5,
    output video_pkg::segments_t hex4,
    output video_pkg::vga_x_t    vga_x,
    output video_pkg::vga_y_t    vga_y,
    output video_pkg::colour_t   vga_colour,
    output logic                 vga_write
);

    logic load_start, draw_start, player_start;
    logic load_done, draw_done, player_done;

    game_pkg::grid_client_t grid_client;
    game_pkg::cell_t        cell_out;

    game_pkg::grid_x_t load_x, draw_x, player_x;
    game_pkg::grid_y_t load_y, draw_y, player_y;
    game_pkg::cell_t   load_cell;
    logic              load_write;

    game_pkg::pos_x_t pos_x;
    game_pkg::pos_y_t pos_y;

    game_sequencer i_game_sequencer (
        .clock(clock), .reset(reset),
        .load_done(load_done), .draw_done(draw_done), .player_done(player_done),
        .load_start(load_start), .draw_start(draw_start), .player_start(player_start),
        .grid_client(grid_client)
    );

    level_loader i_level_loader (
        .clock(clock), .reset(reset), .start(load_start), .done(load_done),
        .grid_x(load_x), .grid_y(load_y), .cell_in(load_cell), .grid_write(load_write)
    );

    grid_memory i_grid_memory (
        .clock(clock), .grid_client(grid_client),
        .load_x(load_x), .load_y(load_y), .load_cell(load_cell), .load_write(load_write),
        .draw_x(draw_x), .draw_y(draw_y),
        .player_x(player_x), .player_y(player_y),
        .cell_out(cell_out)
    );

    draw_grid i_draw_grid (
        .clock(clock), .reset(reset), .start(draw_start), .done(draw_done),
        .grid_x(draw_x), .grid_y(draw_y), .cell_out(cell_out),
        .vga_x(vga_x), .vga_y(vga_y), .vga_colour(vga_colour), .vga_write(vga_write)
    );

    player_updater #(
        .START_X(START_X), .START_Y(START_Y),
        .MOVE_STEP(MOVE_STEP), .TURN_STEP(TURN_STEP)
    ) i_player_updater (
        .clock(clock), .reset(reset), .start(player_start), .done(player_done),
        .turn_right(turn_right), .turn_left(turn_left),
        .move_forward(move_forward), .move_backward(move_backward),
        .grid_x(player_x), .grid_y(player_y), .cell_out(cell_out),
        .pos_x(pos_x), .pos_y(pos_y)
    );

    // Low bytes of the position, X on the left pair
    hex_digit i_hex7 (.value(pos_x[7:4]), .segments(hex7));
    hex_digit i_hex6 (.value(pos_x[3:0]), .segments(hex6));
    hex_digit i_hex5 (.value(pos_y[7:4]), .segments(hex5));
    hex_digit i_hex4 (.value(pos_y[3:0]), .segments(hex4));

endmodule

// ==== hex_digit.sv ====
`timescale 1ns/1ps

module hex_digit (
    input  logic [3:0]           value,
    output video_pkg::segments_t segments
);

    // Segment order gfedcba, low means lit
    always_comb begin
        case (value)
            4'h0:    segments = 7'h40;
            4'h1:    segments = 7'h79;
            4'h2:    segments = 7'h24;
            4'h3:    segments = 7'h30;
            4'h4:    segments = 7'h19;
            4'h5:    segments = 7'h12;
            4'h6:    segments = 7'h02;
            4'h7:    segments = 7'h78;
            4'h8:    segments = 7'h00;
            4'h9:    segments = 7'h10;
            4'ha:    segments = 7'h08;
            4'hb:    segments = 7'h03;
            4'hc:    segments = 7'h46;
            4'hd:    segments = 7'h21;
            4'he:    segments = 7'h06;
            default: segments = 7'h0e;
        endcase
    end

endmodule

// ==== player_updater.sv ====
`timescale 1ns/1ps

module player_updater #(
    parameter game_pkg::pos_x_t START_X   = 384,
    parameter game_pkg::pos_y_t START_Y   = 384,
    parameter int               MOVE_STEP = 16,
    parameter game_pkg::angle_t TURN_STEP = 64
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    output logic              done,
    input  logic              turn_right,
    input  logic              turn_left,
    input  logic              move_forward,
    input  logic              move_backward,
    output game_pkg::grid_x_t grid_x,
    output game_pkg::grid_y_t grid_y,
    input  game_pkg::cell_t   cell_out,
    output game_pkg::pos_x_t  pos_x,
    output game_pkg::pos_y_t  pos_y
);

    localparam game_pkg::pos_x_t STEP_X = game_pkg::pos_x_t'(MOVE_STEP);
    localparam game_pkg::pos_y_t STEP_Y = game_pkg::pos_y_t'(MOVE_STEP);

    game_pkg::angle_t angle;
    game_pkg::angle_t next_angle;
    game_pkg::pos_x_t next_x;
    game_pkg::pos_y_t next_y;
    logic [1:0]       direction;

    game_pkg::angle_t cand_angle;
    game_pkg::pos_x_t cand_x;
    game_pkg::pos_y_t cand_y;
    logic             step_read;
    logic             step_check;

    // Right turn wins over left
    always_comb begin
        next_angle = angle;
        if (turn_right) begin
            next_angle = angle + TURN_STEP;
        end else if (turn_left) begin
            next_angle = angle - TURN_STEP;
        end
    end

    // Quadrant of the old heading: +X, +Y, -X, -Y
    always_comb begin
        direction = angle[7:6];
        if (move_backward && !move_forward) begin
            direction = direction ^ 2'b10;
        end
        next_x = pos_x;
        next_y = pos_y;
        if (move_forward || move_backward) begin
            case (direction)
                2'd0:    next_x = pos_x + STEP_X;
                2'd1:    next_y = pos_y + STEP_Y;
                2'd2:    next_x = pos_x - STEP_X;
                default: next_y = pos_y - STEP_Y;
            endcase
        end
    end

    // Cell under the candidate position
    assign grid_x = game_pkg::grid_x_t'(cand_x >> game_pkg::CELL_SHIFT);
    assign grid_y = game_pkg::grid_y_t'(cand_y >> game_pkg::CELL_SHIFT);

    // Buttons are sampled on the start cycle
    always_ff @(posedge clock) begin
        if (start) begin
            cand_angle <= next_angle;
            cand_x     <= next_x;
            cand_y     <= next_y;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            step_read  <= 1'b0;
            step_check <= 1'b0;
            done       <= 1'b0;
            angle      <= '0;
            pos_x      <= START_X;
            pos_y      <= START_Y;
        end else begin
            step_read  <= start;
            step_check <= step_read;
            done       <= step_check;
            if (step_check) begin
                angle <= cand_angle;
                // Walls block the move but not the turn
                if (cell_out != game_pkg::CELL_WALL) begin
                    pos_x <= cand_x;
                    pos_y <= cand_y;
                end
            end
        end
    end

endmodule

// ==== draw_grid.sv ====
`timescale 1ns/1ps

module draw_grid (
    input  logic               clock,
    input  logic               reset,
    input  logic               start,
    output logic               done,
    output game_pkg::grid_x_t  grid_x,
    output game_pkg::grid_y_t  grid_y,
    input  game_pkg::cell_t    cell_out,
    output video_pkg::vga_x_t  vga_x,
    output video_pkg::vga_y_t  vga_y,
    output video_pkg::colour_t vga_colour,
    output logic               vga_write
);

    // Last pixel of the grid image
    localparam video_pkg::vga_x_t LAST_X =
        video_pkg::vga_x_t'((1 << (game_pkg::GRID_X_BITS + video_pkg::PIXEL_SHIFT)) - 1);
    localparam video_pkg::vga_y_t LAST_Y =
        video_pkg::vga_y_t'((1 << (game_pkg::GRID_Y_BITS + video_pkg::PIXEL_SHIFT)) - 1);

    video_pkg::vga_x_t scan_x;
    video_pkg::vga_y_t scan_y;
    logic              scan_active;
    logic              scan_last;

    assign scan_last = (scan_x == LAST_X) && (scan_y == LAST_Y);

    // Pixel to cell
    assign grid_x = game_pkg::grid_x_t'(scan_x >> video_pkg::PIXEL_SHIFT);
    assign grid_y = game_pkg::grid_y_t'(scan_y >> video_pkg::PIXEL_SHIFT);

    assign vga_colour = (cell_out == game_pkg::CELL_WALL) ?
                        video_pkg::COLOUR_WALL : video_pkg::COLOUR_EMPTY;

    always_ff @(posedge clock) begin
        if (reset) begin
            scan_active <= 1'b0;
            scan_x      <= '0;
            scan_y      <= '0;
            vga_write   <= 1'b0;
            done        <= 1'b0;
        end else begin
            vga_write <= scan_active;
            done      <= vga_write && (vga_x == LAST_X) && (vga_y == LAST_Y);
            if (start) begin
                scan_active <= 1'b1;
                scan_x      <= '0;
                scan_y      <= '0;
            end else if (scan_active) begin
                if (scan_x == LAST_X) begin
                    scan_x <= '0;
                    scan_y <= scan_y + 1'b1;
                end else begin
                    scan_x <= scan_x + 1'b1;
                end
                if (scan_last) begin
                    scan_active <= 1'b0;
                end
            end
        end
    end

    // Coordinates wait one cycle for the grid read
    always_ff @(posedge clock) begin
        vga_x <= scan_x;
        vga_y <= scan_y;
    end

endmodule

// ==== grid_memory.sv ====
`timescale 1ns/1ps

module grid_memory (
    input  logic                   clock,
    input  game_pkg::grid_client_t grid_client,
    input  game_pkg::grid_x_t      load_x,
    input  game_pkg::grid_y_t      load_y,
    input  game_pkg::cell_t        load_cell,
    input  logic                   load_write,
    input  game_pkg::grid_x_t      draw_x,
    input  game_pkg::grid_y_t      draw_y,
    input  game_pkg::grid_x_t      player_x,
    input  game_pkg::grid_y_t      player_y,
    output game_pkg::cell_t        cell_out
);

    localparam int ADDR_BITS = game_pkg::GRID_Y_BITS + game_pkg::GRID_X_BITS;

    game_pkg::cell_t cells [0:(1 << ADDR_BITS)-1];

    logic [ADDR_BITS-1:0] addr;
    logic                 write;

    // Client select, only the loader may write
    always_comb begin
        case (grid_client)
            game_pkg::LOADER: begin
                addr  = {load_y, load_x};
                write = load_write;
            end
            game_pkg::DRAWER: begin
                addr  = {draw_y, draw_x};
                write = 1'b0;
            end
            game_pkg::PLAYER: begin
                addr  = {player_y, player_x};
                write = 1'b0;
            end
            default: begin
                addr  = '0;
                write = 1'b0;
            end
        endcase
    end

    // One cycle read latency
    always_ff @(posedge clock) begin
        if (write) begin
            cells[addr] <= load_cell;
        end
        cell_out <= cells[addr];
    end

endmodule

// ==== level_loader.sv ====
`timescale 1ns/1ps

module level_loader (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    output logic              done,
    output game_pkg::grid_x_t grid_x,
    output game_pkg::grid_y_t grid_y,
    output game_pkg::cell_t   cell_in,
    output logic              grid_write
);

    localparam game_pkg::grid_x_t LAST_X = '1;
    localparam game_pkg::grid_y_t LAST_Y = '1;

    game_pkg::grid_x_t cell_x;
    game_pkg::grid_y_t cell_y;
    logic              active;
    logic              last_cell;
    logic              border;
    logic              pillar;

    assign last_cell = (cell_x == LAST_X) && (cell_y == LAST_Y);

    // Maze rule: closed border plus a pillar every 8 cells
    assign border = (cell_x == '0) || (cell_x == LAST_X) ||
                    (cell_y == '0) || (cell_y == LAST_Y);
    assign pillar = (cell_x[2:0] == 3'd4) && (cell_y[2:0] == 3'd4);

    assign cell_in    = (border || pillar) ? game_pkg::CELL_WALL : game_pkg::CELL_EMPTY;
    assign grid_x     = cell_x;
    assign grid_y     = cell_y;
    assign grid_write = active;

    always_ff @(posedge clock) begin
        if (reset) begin
            active <= 1'b0;
            done   <= 1'b0;
            cell_x <= '0;
            cell_y <= '0;
        end else begin
            done <= active && last_cell;
            if (start) begin
                active <= 1'b1;
                cell_x <= '0;
                cell_y <= '0;
            end else if (active) begin
                // Row-major walk
                cell_x <= cell_x + 1'b1;
                if (cell_x == LAST_X) begin
                    cell_y <= cell_y + 1'b1;
                end
                if (last_cell) begin
                    active <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== game_sequencer.sv ====
`timescale 1ns/1ps

module game_sequencer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  load_done,
    input  logic                  draw_done,
    input  logic                  player_done,
    output logic                  load_start,
    output logic                  draw_start,
    output logic                  player_start,
    output game_pkg::grid_client_t grid_client
);

    typedef enum logic [2:0] {
        LOAD_START,
        LOAD_WAIT,
        DRAW_START,
        DRAW_WAIT,
        PLAYER_START,
        PLAYER_WAIT
    } state_t;

    state_t state;
    state_t next_state;

    // A start state holds until its start pulse has gone out
    always_comb begin
        next_state = state;
        case (state)
            LOAD_START:   next_state = load_start ? LOAD_WAIT : LOAD_START;
            LOAD_WAIT:    next_state = load_done ? DRAW_START : LOAD_WAIT;
            DRAW_START:   next_state = draw_start ? DRAW_WAIT : DRAW_START;
            DRAW_WAIT:    next_state = draw_done ? PLAYER_START : DRAW_WAIT;
            PLAYER_START: next_state = player_start ? PLAYER_WAIT : PLAYER_START;
            PLAYER_WAIT:  next_state = player_done ? DRAW_START : PLAYER_WAIT;
            default:      next_state = LOAD_START;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= LOAD_START;
            load_start   <= 1'b0;
            draw_start   <= 1'b0;
            player_start <= 1'b0;
        end else begin
            state        <= next_state;
            // Registered so the pulse lines up with the start state
            load_start   <= (next_state == LOAD_START) && !load_start;
            draw_start   <= (next_state == DRAW_START) && !draw_start;
            player_start <= (next_state == PLAYER_START) && !player_start;
        end
    end

    // Grid belongs to the stage that is running
    always_comb begin
        case (state)
            LOAD_WAIT:   grid_client = game_pkg::LOADER;
            DRAW_WAIT:   grid_client = game_pkg::DRAWER;
            PLAYER_WAIT: grid_client = game_pkg::PLAYER;
            default:     grid_client = game_pkg::NONE;
        endcase
    end

endmodule

// ==== video_pkg.sv ====
package video_pkg;

    // VGA adapter coordinates and colour
    typedef logic [7:0]  vga_x_t;
    typedef logic [6:0]  vga_y_t;
    typedef logic [17:0] colour_t;

    localparam colour_t COLOUR_WALL  = '1;
    localparam colour_t COLOUR_EMPTY = '0;

    // One cell is 2 x 2 pixels
    localparam int PIXEL_SHIFT = 1;

    // Active low, bit 0 is segment a
    typedef logic [6:0] segments_t;

endpackage

// ==== game_pkg.sv ====
package game_pkg;

    // Grid geometry
    localparam int GRID_X_BITS = 6;
    localparam int GRID_Y_BITS = 5;

    typedef logic [GRID_X_BITS-1:0] grid_x_t;
    typedef logic [GRID_Y_BITS-1:0] grid_y_t;

    // Cell codes
    typedef logic [2:0] cell_t;

    localparam cell_t CELL_EMPTY = 3'd0;
    localparam cell_t CELL_WALL  = 3'd1;

    // Player state, fixed point with CELL_SHIFT fraction bits per cell
    typedef logic [13:0] pos_x_t;
    typedef logic [12:0] pos_y_t;
    typedef logic [7:0]  angle_t;

    localparam int CELL_SHIFT = 6;

    // Owner of the grid port
    typedef enum logic [1:0] {
        LOADER,
        DRAWER,
        PLAYER,
        NONE
    } grid_client_t;

endpackage
